//--- hdl/fu_consts.svh
`ifndef FU_CONSTS_SVH
`define FU_CONSTS_SVH

// datapath width, RV32
`define XLEN 32

// unit counts in the execute bank
`define NUM_FU_ALU  2
`define NUM_FU_MULT 1

// multiplier depth: operand stage, accumulate stages, output stage
// accumulate stages = MULT_STAGES - 2, must divide the four partial products
`define MULT_STAGES 4

// tag widths
`define PRN_W  6   // physical register tag
`define ROBN_W 5   // reorder buffer index

// debug fill words, easy to spot in waves
`define FILL_BAD_A   32'hdeadface   // opa select out of range
`define FILL_BAD_B   32'hfacefeed   // opb select out of range
`define FILL_BAD_ALU 32'hfacebeec   // alu func out of range

`endif

//--- hdl/fu_pkg.sv
`default_nettype none
`include "fu_consts.svh"

package fu_pkg;

    typedef logic [`XLEN-1:0]   data_t;
    typedef logic [`XLEN-1:0]   addr_t;
    typedef logic [`PRN_W-1:0]  prn_t;
    typedef logic [`ROBN_W-1:0] robn_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_t;

    // same order as the RV32M funct3 codes
    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,
        MUL_H   = 2'd1,
        MUL_HSU = 2'd2,
        MUL_HU  = 2'd3
    } mult_func_t;

    // function field, read as alu or mult depending on the unit
    typedef union packed {
        alu_func_t alu;
        struct packed {
            logic [1:0] rsvd;   // zero for mult ops
            mult_func_t op;
        } mult;
    } fu_func_u;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_PC   = 2'd1,
        OPA_IS_ZERO = 2'd2
    } opa_sel_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_t;

    // instruction word in the six base formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2, rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

    typedef struct packed {
        logic      valid;
        rv_inst_u  inst;
        addr_t     pc;
        fu_func_u  func;
        data_t     op1;
        data_t     op2;
        prn_t      dest_prn;
        robn_t     robn;
        opa_sel_t  opa_select;
        opb_sel_t  opb_select;
        logic      cond_branch;
        logic      uncond_branch;
    } fu_packet_t;

    typedef struct packed {
        robn_t robn;
        prn_t  dest_prn;
        data_t result;
    } fu_result_t;

    typedef struct packed {
        fu_result_t basic;
        logic       take_branch;
        logic       cond_branch;
        logic       uncond_branch;
    } fu_alu_result_t;

    // branch outcome report to the ROB
    typedef struct packed {
        robn_t robn;
        logic  executed;
        logic  branch_taken;
        addr_t target_addr;
    } fu_rob_packet_t;

endpackage

`default_nettype wire

//--- hdl/operand_select.sv
`timescale 1ns/100ps
`default_nettype none
`include "fu_consts.svh"

// operand muxes shared by every functional unit
module operand_select (
    input  fu_pkg::fu_packet_t packet,
    output fu_pkg::data_t      opa,
    output fu_pkg::data_t      opb
);

    fu_pkg::rv_inst_u inst;

    assign inst = packet.inst;

    always_comb begin
        case (packet.opa_select)
            fu_pkg::OPA_IS_RS1:  opa = packet.op1;
            fu_pkg::OPA_IS_PC:   opa = packet.pc;   // auipc, jal link calc
            fu_pkg::OPA_IS_ZERO: opa = '0;          // lui
            default:             opa = `FILL_BAD_A;
        endcase
    end

    // immediates rebuilt from the format views, sign bit is always inst[31]
    always_comb begin
        case (packet.opb_select)
            fu_pkg::OPB_IS_RS2:   opb = packet.op2;
            fu_pkg::OPB_IS_I_IMM: opb = {{20{inst.i.imm[11]}}, inst.i.imm};
            fu_pkg::OPB_IS_S_IMM: opb = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5,
                                         inst.s.imm4_0};
            fu_pkg::OPB_IS_B_IMM: opb = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                                         inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            fu_pkg::OPB_IS_U_IMM: opb = {inst.u.imm31_12, 12'b0};   // upper 20, low zero
            fu_pkg::OPB_IS_J_IMM: opb = {{11{inst.j.imm20}}, inst.j.imm20,
                                         inst.j.imm19_12, inst.j.imm11,
                                         inst.j.imm10_1, 1'b0};
            default:              opb = `FILL_BAD_B;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "fu_consts.svh"

// combinational integer alu, rv32i register and immediate ops
module alu (
    input  fu_pkg::data_t     opa,
    input  fu_pkg::data_t     opb,
    input  fu_pkg::alu_func_t func,
    output fu_pkg::data_t     result
);

    logic signed [`XLEN-1:0] sopa;   // signed views for slt and sra
    logic signed [`XLEN-1:0] sopb;

    assign sopa = opa;
    assign sopb = opb;

    always_comb begin
        case (func)
            fu_pkg::ALU_ADD:  result = opa + opb;
            fu_pkg::ALU_SUB:  result = opa - opb;
            fu_pkg::ALU_AND:  result = opa & opb;
            fu_pkg::ALU_OR:   result = opa | opb;
            fu_pkg::ALU_XOR:  result = opa ^ opb;
            fu_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, sopa < sopb};
            fu_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, opa < opb};
            // shift amount is the low five bits only
            fu_pkg::ALU_SLL:  result = opa << opb[4:0];
            fu_pkg::ALU_SRL:  result = opa >> opb[4:0];
            fu_pkg::ALU_SRA:  result = sopa >>> opb[4:0];
            default:          result = `FILL_BAD_ALU;   // no latch, marks bad decode
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/branch_cond.sv
`timescale 1ns/100ps
`default_nettype none

// conditional branch compare, funct3 straight from the b-format word
module branch_cond (
    input  logic [2:0]    funct3,
    input  fu_pkg::data_t rs1,
    input  fu_pkg::data_t rs2,
    output logic          take
);

    always_comb begin
        case (funct3)
            3'b000:  take = (rs1 == rs2);                   // beq
            3'b001:  take = (rs1 != rs2);                   // bne
            3'b100:  take = ($signed(rs1) < $signed(rs2));  // blt
            3'b101:  take = ($signed(rs1) >= $signed(rs2)); // bge
            3'b110:  take = (rs1 < rs2);                    // bltu
            3'b111:  take = (rs1 >= rs2);                   // bgeu
            default: take = 1'b0;   // 010, 011 reserved
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

// one alu functional unit, result ready in the issue cycle
module alu_unit (
    input  logic                   clock,   // unused, unit is combinational
    input  logic                   rst,     // unused, no state to clear
    input  fu_pkg::fu_packet_t     packet,
    output logic                   prepared,
    output fu_pkg::fu_alu_result_t res
);

    fu_pkg::data_t opa;
    fu_pkg::data_t opb;
    fu_pkg::data_t alu_out;
    logic          cond_take;

    operand_select u_opsel (
        .packet (packet),
        .opa    (opa),
        .opb    (opb)
    );

    alu u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (packet.func.alu),
        .result (alu_out)
    );

    // compare uses the raw register values, not the muxed operands
    branch_cond u_bcond (
        .funct3 (packet.inst.b.funct3),
        .rs1    (packet.op1),
        .rs2    (packet.op2),
        .take   (cond_take)
    );

    assign prepared           = packet.valid;
    assign res.basic.robn     = packet.robn;
    assign res.basic.dest_prn = packet.dest_prn;
    assign res.basic.result   = alu_out;   // target addr for branches
    assign res.cond_branch    = packet.cond_branch;
    assign res.uncond_branch  = packet.uncond_branch;
    assign res.take_branch    = packet.uncond_branch | (packet.cond_branch & cond_take);

endmodule

`default_nettype wire

//--- hdl/mult_pipe.sv
`timescale 1ns/100ps
`default_nettype none
`include "fu_consts.svh"

// pipelined 32x32 multiplier, whole pipe frozen while avail is low
module mult_pipe (
    input  logic               clock,
    input  logic               rst,
    input  fu_pkg::fu_packet_t packet,
    input  logic               avail,
    output logic               done,
    output fu_pkg::fu_result_t res
);

    localparam int MID    = `MULT_STAGES - 2;   // accumulate stages
    localparam int PP_PER = 4 / MID;            // 16-bit partial products per stage
    localparam int STEP   = 16 * PP_PER;        // multiplier bits eaten per stage

    fu_pkg::data_t      opa;
    fu_pkg::data_t      opb;
    fu_pkg::mult_func_t mfunc;
    logic               sign_a;
    logic               sign_b;

    logic               s1_valid;
    logic               s1_high;
    logic [32:0]        s1_a;       // sign or zero extended per func
    logic [32:0]        s1_b;
    fu_pkg::robn_t      s1_robn;
    fu_pkg::prn_t       s1_prn;

    logic [MID-1:0]     m_valid;
    logic [MID-1:0]     m_high;
    fu_pkg::robn_t      m_robn [MID];
    fu_pkg::prn_t       m_prn  [MID];
    logic [63:0]        m_acc  [MID];
    logic [63:0]        m_a    [MID-1];   // shifted multiplicand
    logic [63:0]        m_b    [MID-1];   // remaining multiplier bits

    logic [63:0]        src_a   [MID];
    logic [63:0]        src_b   [MID];
    logic [63:0]        src_acc [MID];
    logic [63:0]        nxt_acc [MID];

    operand_select u_opsel (
        .packet (packet),
        .opa    (opa),
        .opb    (opb)
    );

    assign mfunc = packet.func.mult.op;

    always_comb begin
        case (mfunc)
            fu_pkg::MUL_HSU: {sign_a, sign_b} = 2'b10;
            fu_pkg::MUL_HU:  {sign_a, sign_b} = 2'b00;
            default:         {sign_a, sign_b} = 2'b11;   // mul, mulh
        endcase
    end

    // operands of stage k, then its partial products added on
    always_comb begin
        logic [63:0] pp;
        src_a[0]   = {{31{s1_a[32]}}, s1_a};
        src_b[0]   = {{31{s1_b[32]}}, s1_b};
        src_acc[0] = '0;
        for (int k = 1; k < MID; k++) begin
            src_a[k]   = m_a[k-1];
            src_b[k]   = m_b[k-1];
            src_acc[k] = m_acc[k-1];
        end
        for (int k = 0; k < MID; k++) begin
            pp = '0;
            for (int j = 0; j < PP_PER; j++) begin
                pp = pp + ((src_a[k] * {48'b0, src_b[k][16*j +: 16]}) << (16 * j));
            end
            nxt_acc[k] = src_acc[k] + pp;   // product mod 2^64 at the end
        end
    end

    // valid chain
    always_ff @(posedge clock) begin
        if (rst) begin
            s1_valid <= 1'b0;
            m_valid  <= '0;
            done     <= 1'b0;
        end else if (avail) begin
            s1_valid   <= packet.valid;
            m_valid[0] <= s1_valid;
            for (int k = 1; k < MID; k++) begin
                m_valid[k] <= m_valid[k-1];
            end
            done <= m_valid[MID-1];
        end
    end

    // datapath and tags
    always_ff @(posedge clock) begin
        if (avail) begin
            s1_a      <= {sign_a & opa[31], opa};
            s1_b      <= {sign_b & opb[31], opb};
            s1_high   <= (mfunc != fu_pkg::MUL_LO);
            s1_robn   <= packet.robn;
            s1_prn    <= packet.dest_prn;
            m_high[0] <= s1_high;
            m_robn[0] <= s1_robn;
            m_prn[0]  <= s1_prn;
            for (int k = 1; k < MID; k++) begin
                m_high[k] <= m_high[k-1];
                m_robn[k] <= m_robn[k-1];
                m_prn[k]  <= m_prn[k-1];
            end
            for (int k = 0; k < MID; k++) begin
                m_acc[k] <= nxt_acc[k];
            end
            for (int k = 0; k < MID - 1; k++) begin
                m_a[k] <= src_a[k] << STEP;
                m_b[k] <= src_b[k] >> STEP;
            end
            res.robn     <= m_robn[MID-1];
            res.dest_prn <= m_prn[MID-1];
            res.result   <= m_high[MID-1] ? m_acc[MID-1][63:32] : m_acc[MID-1][31:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/fu_bank.sv
`timescale 1ns/100ps
`default_nettype none
`include "fu_consts.svh"

// execute stage, alu and multiplier units side by side
module fu_bank (
    input  logic                                       clock,
    input  logic                                       rst,
    input  fu_pkg::fu_packet_t     [`NUM_FU_ALU-1:0]  alu_packet,
    input  fu_pkg::fu_packet_t     [`NUM_FU_MULT-1:0] mult_packet,
    input  logic                   [`NUM_FU_MULT-1:0] mult_avail,   // from wb arbiter
    output logic                   [`NUM_FU_ALU-1:0]  alu_prepared,
    output fu_pkg::fu_alu_result_t [`NUM_FU_ALU-1:0]  alu_result,
    output logic                   [`NUM_FU_MULT-1:0] mult_done,
    output fu_pkg::fu_result_t     [`NUM_FU_MULT-1:0] mult_result,
    output fu_pkg::fu_rob_packet_t [`NUM_FU_ALU-1:0]  cond_rob_packet
);

    for (genvar i = 0; i < `NUM_FU_ALU; i++) begin : g_alu
        alu_unit u_alu_unit (
            .clock    (clock),
            .rst      (rst),
            .packet   (alu_packet[i]),
            .prepared (alu_prepared[i]),
            .res      (alu_result[i])
        );
    end

    for (genvar i = 0; i < `NUM_FU_MULT; i++) begin : g_mult
        mult_pipe u_mult_pipe (
            .clock  (clock),
            .rst    (rst),
            .packet (mult_packet[i]),
            .avail  (mult_avail[i]),
            .done   (mult_done[i]),
            .res    (mult_result[i])
        );
    end

    // rob only cares about cond branches, jumps are resolved elsewhere
    always_comb begin
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            cond_rob_packet[i].robn         = alu_result[i].basic.robn;
            cond_rob_packet[i].executed     = alu_prepared[i] & alu_result[i].cond_branch;
            cond_rob_packet[i].branch_taken = alu_result[i].take_branch;
            cond_rob_packet[i].target_addr  = alu_result[i].basic.result;
        end
    end

endmodule

`default_nettype wire

//--- dv/fu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "fu_consts.svh"

module fu_tb;

    localparam int MAX_CYCLES = 3000;   // vectors plus stall slack

    // one expected multiply with its issue stamp in avail-high edges
    typedef struct packed {
        int            stamp;
        fu_pkg::robn_t robn;
        fu_pkg::prn_t  prn;
        fu_pkg::data_t result;
    } mult_exp_t;

    logic                                       clock;
    logic                                       rst;
    fu_pkg::fu_packet_t     [`NUM_FU_ALU-1:0]  alu_packet;
    fu_pkg::fu_packet_t     [`NUM_FU_MULT-1:0] mult_packet;
    logic                   [`NUM_FU_MULT-1:0] mult_avail;
    logic                   [`NUM_FU_ALU-1:0]  alu_prepared;
    fu_pkg::fu_alu_result_t [`NUM_FU_ALU-1:0]  alu_result;
    logic                   [`NUM_FU_MULT-1:0] mult_done;
    fu_pkg::fu_result_t     [`NUM_FU_MULT-1:0] mult_result;
    fu_pkg::fu_rob_packet_t [`NUM_FU_ALU-1:0]  cond_rob_packet;

    integer             seed;
    int                 errors;
    int                 cycles;
    int                 adv       [`NUM_FU_MULT];   // avail-high edges so far
    mult_exp_t          pend      [`NUM_FU_MULT][$];
    logic               stalled   [`NUM_FU_MULT];   // last edge had avail low
    logic               held_done [`NUM_FU_MULT];
    fu_pkg::fu_result_t held_res  [`NUM_FU_MULT];

    fu_bank uut (
        .clock           (clock),
        .rst             (rst),
        .alu_packet      (alu_packet),
        .mult_packet     (mult_packet),
        .mult_avail      (mult_avail),
        .alu_prepared    (alu_prepared),
        .alu_result      (alu_result),
        .mult_done       (mult_done),
        .mult_result     (mult_result),
        .cond_rob_packet (cond_rob_packet)
    );

    always #50 clock = ~clock;   // 100 ns period

    // returns {opa, opb} with immediates from the rv32 bit positions
    function automatic logic [63:0] ref_operands(fu_pkg::fu_packet_t p);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        w = p.inst;
        case (p.opa_select)
            fu_pkg::OPA_IS_RS1:  a = p.op1;
            fu_pkg::OPA_IS_PC:   a = p.pc;
            fu_pkg::OPA_IS_ZERO: a = 32'h0;
            default:             a = `FILL_BAD_A;
        endcase
        case (p.opb_select)
            fu_pkg::OPB_IS_RS2:   b = p.op2;
            fu_pkg::OPB_IS_I_IMM: b = {{20{w[31]}}, w[31:20]};
            fu_pkg::OPB_IS_S_IMM: b = {{20{w[31]}}, w[31:25], w[11:7]};
            fu_pkg::OPB_IS_B_IMM: b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            fu_pkg::OPB_IS_U_IMM: b = {w[31:12], 12'h0};
            fu_pkg::OPB_IS_J_IMM: b = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:              b = `FILL_BAD_B;
        endcase
        return {a, b};
    endfunction

    function automatic fu_pkg::data_t ref_alu(fu_pkg::data_t a, fu_pkg::data_t b,
                                              fu_pkg::alu_func_t f);
        case (f)
            fu_pkg::ALU_ADD:  return a + b;
            fu_pkg::ALU_SUB:  return a - b;
            fu_pkg::ALU_AND:  return a & b;
            fu_pkg::ALU_OR:   return a | b;
            fu_pkg::ALU_XOR:  return a ^ b;
            fu_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            fu_pkg::ALU_SLTU: return {31'b0, a < b};
            fu_pkg::ALU_SLL:  return a << b[4:0];
            fu_pkg::ALU_SRL:  return a >> b[4:0];
            fu_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            default:          return `FILL_BAD_ALU;
        endcase
    endfunction

    function automatic logic ref_branch(logic [2:0] f3, fu_pkg::data_t x, fu_pkg::data_t y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;   // reserved codes never branch
        endcase
    endfunction

    function automatic fu_pkg::data_t ref_mult(fu_pkg::data_t a, fu_pkg::data_t b,
                                               fu_pkg::mult_func_t f);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        ea   = {{32{a[31] & (f != fu_pkg::MUL_HU)}}, a};   // rs1 unsigned only for mulhu
        eb   = {{32{b[31] & (f == fu_pkg::MUL_LO || f == fu_pkg::MUL_H)}}, b};
        prod = ea * eb;   // low 64 bits of the extended product
        return (f == fu_pkg::MUL_LO) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // corner values mixed with plain random words
    function automatic fu_pkg::data_t pick_operand();
        case ($unsigned($random(seed)) % 5)
            0:       return 32'h8000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h0;
            default: return $random(seed);
        endcase
    endfunction

    function automatic fu_pkg::fu_packet_t random_alu_packet();
        fu_pkg::fu_packet_t p;
        int                 kind;
        p       = '0;
        p.valid = (($random(seed) & 7) != 0);   // mostly valid
        p.inst  = $random(seed);                // random funct3 incl 010, 011
        p.pc    = $random(seed) & ~32'h3;
        p.op1   = pick_operand();
        case ($unsigned($random(seed)) % 4)
            0:       p.op2 = p.op1;                   // equal
            1:       p.op2 = p.op1 + 1;               // just above
            2:       p.op2 = p.op1 ^ 32'h8000_0000;   // signed and unsigned order differ
            default: p.op2 = pick_operand();
        endcase
        p.func.alu     = fu_pkg::alu_func_t'($unsigned($random(seed)) % 10);
        p.dest_prn     = fu_pkg::prn_t'($random(seed));
        p.robn         = fu_pkg::robn_t'($random(seed));
        p.opa_select   = fu_pkg::opa_sel_t'($unsigned($random(seed)) % 3);
        p.opb_select   = fu_pkg::opb_sel_t'($unsigned($random(seed)) % 6);
        kind           = $unsigned($random(seed)) % 3;   // plain, cond or jump
        p.cond_branch   = (kind == 1);
        p.uncond_branch = (kind == 2);
        return p;
    endfunction

    function automatic fu_pkg::fu_packet_t build_mult_packet();
        fu_pkg::fu_packet_t p;
        p             = '0;
        p.valid       = 1'b1;
        p.inst        = $random(seed);
        p.op1         = pick_operand();
        p.op2         = pick_operand();
        p.func.mult.op = fu_pkg::mult_func_t'($unsigned($random(seed)) % 4);
        p.dest_prn    = fu_pkg::prn_t'($random(seed));
        p.robn        = fu_pkg::robn_t'($random(seed));
        p.opa_select  = fu_pkg::OPA_IS_RS1;
        p.opb_select  = fu_pkg::OPB_IS_RS2;
        return p;
    endfunction

    function automatic int in_flight();
        int n;
        n = 0;
        for (int m = 0; m < `NUM_FU_MULT; m++)
            n += pend[m].size();
        return n;
    endfunction

    // issue only while avail is high, stall_pct sets how often avail drops
    task automatic run_mults(input int n, input int stall_pct);
        repeat (n) begin
            for (int m = 0; m < `NUM_FU_MULT; m++) begin
                mult_avail[m] = ($unsigned($random(seed)) % 100) >= stall_pct;
                if (mult_avail[m])
                    mult_packet[m] = build_mult_packet();
                else
                    mult_packet[m] = '0;   // nothing offered into a frozen pipe
            end
            @(negedge clock);
        end
    endtask

    // with avail high everything in flight finishes within the pipe depth
    task automatic drain_mults();
        int waited;
        waited      = 0;
        mult_avail  = '1;
        mult_packet = '0;
        while (in_flight() != 0 && waited <= `MULT_STAGES) begin
            @(negedge clock);
            waited++;
        end
        check(64'(in_flight()), 64'(0), "results still in flight after drain");
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    // registers read here still hold the values from before this edge
    always @(posedge clock) begin : compare
        fu_pkg::fu_packet_t p;
        logic [63:0]        ops;
        fu_pkg::data_t      exp_res;
        logic               exp_take;
        int                 now;
        mult_exp_t          e;
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            p        = alu_packet[i];
            ops      = ref_operands(p);
            exp_res  = ref_alu(ops[63:32], ops[31:0], p.func.alu);
            exp_take = p.uncond_branch | (p.cond_branch & ref_branch(p.inst[14:12], p.op1, p.op2));
            check(64'(alu_prepared[i]), 64'(p.valid), "alu_prepared");
            check(64'(cond_rob_packet[i].executed), 64'(p.valid & p.cond_branch), "rob executed");
            if (p.valid) begin
                check(64'(alu_result[i].basic.result), 64'(exp_res), "alu result");
                check(64'(alu_result[i].basic.robn), 64'(p.robn), "alu robn");
                check(64'(alu_result[i].basic.dest_prn), 64'(p.dest_prn), "alu dest_prn");
                check(64'(alu_result[i].cond_branch), 64'(p.cond_branch), "alu cond_branch");
                check(64'(alu_result[i].uncond_branch), 64'(p.uncond_branch),
                      "alu uncond_branch");
                check(64'(alu_result[i].take_branch), 64'(exp_take), "take_branch");
                check(64'(cond_rob_packet[i].robn), 64'(p.robn), "rob robn");
                check(64'(cond_rob_packet[i].branch_taken), 64'(exp_take), "rob branch_taken");
                check(64'(cond_rob_packet[i].target_addr), 64'(exp_res), "rob target_addr");
            end
        end
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            if (rst) begin
                pend[m].delete();   // in-flight work is dropped by reset
                stalled[m] = 1'b0;
            end else begin
                now = adv[m];
                if (stalled[m]) begin
                    check(64'(mult_done[m]), 64'(held_done[m]), "mult_done moved in stall");
                    check(64'(mult_result[m]), 64'(held_res[m]), "mult_result moved in stall");
                end
                if (pend[m].size() == 0) begin
                    check(64'(mult_done[m]), 64'(0), "mult_done with nothing in flight");
                end else begin
                    e = pend[m][0];
                    check(64'(mult_done[m]), 64'(now - e.stamp == `MULT_STAGES), "mult latency");
                    if (mult_done[m] && mult_avail[m]) begin
                        void'(pend[m].pop_front());   // arbiter takes it this edge
                        check(64'(mult_result[m].robn), 64'(e.robn), "mult robn");
                        check(64'(mult_result[m].dest_prn), 64'(e.prn), "mult dest_prn");
                        check(64'(mult_result[m].result), 64'(e.result), "mult result");
                    end
                end
                if (mult_avail[m] && mult_packet[m].valid) begin
                    ops      = ref_operands(mult_packet[m]);
                    e.stamp  = now;
                    e.robn   = mult_packet[m].robn;
                    e.prn    = mult_packet[m].dest_prn;
                    e.result = ref_mult(ops[63:32], ops[31:0], mult_packet[m].func.mult.op);
                    pend[m].push_back(e);
                end
                stalled[m]   = !mult_avail[m];
                held_done[m] = mult_done[m];
                held_res[m]  = mult_result[m];
                if (mult_avail[m])
                    adv[m]++;
            end
        end
    end

    initial begin
        seed        = 92;
        errors      = 0;
        cycles      = 0;
        clock       = 1'b0;
        rst         = 1'b1;
        alu_packet  = '0;
        mult_packet = '0;
        mult_avail  = '1;
        repeat (5) @(negedge clock);
        rst = 1'b0;
        repeat (400) begin   // alu ops and branches on both units every cycle
            for (int i = 0; i < `NUM_FU_ALU; i++)
                alu_packet[i] = random_alu_packet();
            @(negedge clock);
        end
        alu_packet = '0;
        run_mults(100, 0);    // back to back
        drain_mults();
        run_mults(300, 35);   // random back-pressure
        drain_mults();
        run_mults(6, 0);      // leave work in flight and reset over it
        mult_packet = '0;
        rst         = 1'b1;
        repeat (2) @(negedge clock);
        rst = 1'b0;
        repeat (`MULT_STAGES + 2) @(negedge clock);   // done must stay low here
        run_mults(20, 20);
        drain_mults();
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/fu_pkg.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/branch_cond.sv
hdl/alu_unit.sv
hdl/mult_pipe.sv
hdl/fu_bank.sv
dv/fu_tb.sv

//--- Makefile
# Verilator flow for the execute stage testbench

TOP = fu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

# pass only when the run prints the pass line
sim:
	verilator --binary --timing --top-module $(TOP) -f verilog.f -o fu_sim
	out="$$(./obj_dir/fu_sim)"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
